/* decode_buffer.sv */
`timescale 1ns/10ps

module decode_buffer
    import fetch_pkg::*;
#(
    parameter int BUF_BYTES = 128
) (
    input  logic        bus,
    input  logic        rst_n,
    input  chunk_t      chunk,
    input  logic [3:0]  consume,
    input  logic        flush,
    output window_t     window,
    output logic        window_valid,
    output logic [3:0]  free_lines,
    output logic        line_written
);

    localparam int PTR_W     = $clog2(BUF_BYTES);
    localparam int EXT_BYTES = BUF_BYTES + WINDOW_BYTES;

    logic [BUF_BYTES*8-1:0]    buf_q;      // Byte i at bits [i*8 +: 8]
    logic [BUF_BYTES*8-1:0]    buf_d;
    logic [EXT_BYTES*8-1:0]    buf_ext;
    logic [WINDOW_BYTES*8-1:0] win_raw;

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   fill;
    logic [PTR_W:0]   free_bytes;
    logic [PTR_W:0]   free_blocks;
    logic [PTR_W:0]   wr_amt;
    logic [PTR_W:0]   rd_amt;
    logic             do_write;

    assign do_write = chunk.valid && !flush;
    assign wr_amt   = do_write ? (PTR_W+1)'(chunk.count) : '0;
    assign rd_amt   = window_valid ? (PTR_W+1)'(consume) : '0;

    assign window_valid = fill >= (PTR_W+1)'(WINDOW_BYTES);

    // Whole free lines, saturated to the port width
    assign free_bytes  = (PTR_W+1)'(BUF_BYTES) - fill;
    assign free_blocks = free_bytes >> OFFS_W;
    assign free_lines  = (free_blocks > (PTR_W+1)'(15)) ? 4'd15 : free_blocks[3:0];

    // Credit returns at the edge that writes the chunk
    assign line_written = chunk.valid;

    // Scatter the chunk from the write offset on, wrapping at the end
    always_comb begin
        logic [PTR_W-1:0] idx;
        buf_d = buf_q;
        for (int k = 0; k < LINE_BYTES; k++) begin
            idx = wr_ptr + PTR_W'(k);
            if (do_write && ((OFFS_W+1)'(k) < chunk.count)) begin
                buf_d[idx*8 +: 8] = chunk.bytes[(LINE_BYTES-1-k)*8 +: 8];
            end
        end
    end

    always_ff @(posedge bus) begin
        buf_q <= buf_d;
    end

    // Head repeated past the end so the window never wraps
    assign buf_ext = {buf_q[WINDOW_BYTES*8-1:0], buf_q};
    assign win_raw = buf_ext[rd_ptr*8 +: WINDOW_BYTES*8];

    always_comb begin
        for (int k = 0; k < WINDOW_BYTES; k++) begin
            window[(WINDOW_BYTES-1-k)*8 +: 8] = win_raw[k*8 +: 8];   // Byte 0 to the top
        end
    end

    always_ff @(posedge bus) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fill   <= '0;
        end else if (flush) begin
            rd_ptr <= wr_ptr;                  // Empty, pointers meet
            fill   <= '0;
        end else begin
            wr_ptr <= wr_ptr + wr_amt[PTR_W-1:0];
            rd_ptr <= rd_ptr + rd_amt[PTR_W-1:0];
            fill   <= fill + wr_amt - rd_amt;
        end
    end

endmodule

/* fetch_pkg.sv */
package fetch_pkg;

    localparam int ADDR_W       = 64;
    localparam int LINE_BYTES   = 64;
    localparam int OFFS_W       = 6;     // log2 of LINE_BYTES
    localparam int WINDOW_BYTES = 15;    // Longest x86 instruction

    // Byte addresses, line aligned whenever they go out on the bus
    typedef logic [ADDR_W-1:0] line_addr_t;

    // Whole cache line, byte 0 in the top bits
    typedef logic [LINE_BYTES*8-1:0] line_data_t;

    // Decode window, byte 0 in the top bits
    typedef logic [WINDOW_BYTES*8-1:0] window_t;

    // Line as it leaves the requester
    typedef struct packed {
        logic              valid;
        logic              discard;   // Issued before the latest redirect
        logic [OFFS_W-1:0] skip;      // Leading bytes to drop
        line_data_t        data;
    } line_resp_t;

    // Aligned bytes headed for the decode buffer
    typedef struct packed {
        logic              valid;
        line_data_t        bytes;     // Byte 0 at the top
        logic [OFFS_W:0]   count;     // 1 to 64
    } chunk_t;

    // Feedback from the decoder
    typedef struct packed {
        logic [3:0]  consume;         // Bytes taken this cycle
        logic        redirect;        // One-cycle pulse
        line_addr_t  target;
    } decode_ctl_t;

endpackage

/* fetch_requester.sv */
`timescale 1ns/10ps

module fetch_requester
    import fetch_pkg::*;
(
    input  logic        bus,
    input  logic        rst_n,
    input  line_addr_t  entry,
    output line_addr_t  req_addr,
    output logic        reqcyc,
    input  logic        reqack,
    input  logic        respcyc,
    input  line_data_t  resp,
    input  logic        redirect,
    input  line_addr_t  target,
    input  logic [3:0]  free_lines,
    input  logic        line_written,
    output line_resp_t  line_out
);

    typedef enum logic [1:0] {
        ST_IDLE,    // Waiting for buffer credit
        ST_REQ,     // reqcyc up, waiting for reqack
        ST_WAIT     // Turnaround after the acknowledge
    } state_t;

    state_t            state;
    line_addr_t        fetch_addr;
    logic [OFFS_W-1:0] head_skip;      // Skip for the next fresh response
    logic [3:0]        pending;        // Acked lines not yet through the aligner
    logic [3:0]        in_flight;      // Acked lines with no response yet
    logic [3:0]        in_flight_next;
    logic [3:0]        stale;          // Responses still owed from before a redirect
    logic              acked;
    logic              drop;

    assign acked  = (state == ST_REQ) && reqack;
    assign drop   = redirect || (stale != 4'd0);   // Current response is stale
    assign reqcyc = (state == ST_REQ);
    assign req_addr = fetch_addr;                  // Stable while reqcyc is up

    assign in_flight_next = in_flight + {3'b000, acked} - {3'b000, respcyc};

    always_ff @(posedge bus) begin
        if (!rst_n) begin
            state      <= ST_IDLE;
            fetch_addr <= {entry[ADDR_W-1:OFFS_W], {OFFS_W{1'b0}}};
            head_skip  <= entry[OFFS_W-1:0];
        end else if (redirect) begin
            // Abandon any unacked request and restart at the target line
            state      <= ST_IDLE;
            fetch_addr <= {target[ADDR_W-1:OFFS_W], {OFFS_W{1'b0}}};
            head_skip  <= target[OFFS_W-1:0];
        end else begin
            if (respcyc && !drop) begin
                head_skip <= '0;               // Only the first line is trimmed
            end
            case (state)
                ST_IDLE: begin
                    if (pending < free_lines) begin
                        state <= ST_REQ;
                    end
                end
                ST_REQ: begin
                    if (reqack) begin
                        state      <= ST_WAIT;
                        fetch_addr <= fetch_addr + line_addr_t'(LINE_BYTES);
                    end
                end
                ST_WAIT: state <= ST_IDLE;     // reqcyc low for this cycle
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Credit and stale bookkeeping
    always_ff @(posedge bus) begin
        if (!rst_n) begin
            pending   <= 4'd0;
            in_flight <= 4'd0;
            stale     <= 4'd0;
        end else begin
            pending   <= pending + {3'b000, acked} - {3'b000, line_written};
            in_flight <= in_flight_next;
            if (redirect) begin
                stale <= in_flight_next;       // Everything still owed is now old
            end else if (respcyc && (stale != 4'd0)) begin
                stale <= stale - 4'd1;
            end
        end
    end

    always_comb begin
        line_out.valid   = respcyc;
        line_out.discard = drop;
        line_out.skip    = drop ? '0 : head_skip;
        line_out.data    = resp;
    end

endmodule

/* fetch_unit.sv */
`timescale 1ns/10ps

module fetch_unit
    import fetch_pkg::*;
#(
    parameter int BUF_BYTES = 128
) (
    input  logic         bus,
    input  logic         rst_n,
    input  line_addr_t   entry,
    output line_addr_t   req_addr,
    output logic         reqcyc,
    input  logic         reqack,
    input  logic         respcyc,
    input  line_data_t   resp,
    input  decode_ctl_t  dec_ctl,
    output window_t      window,
    output logic         window_valid
);

    line_resp_t  line_resp;
    chunk_t      chunk;
    logic [3:0]  free_lines;
    logic        line_written;
    logic        credit_return;

    // A line either becomes a chunk or returns credit, never both in one cycle
    fetch_requester i_requester (
        .bus          (bus),
        .rst_n        (rst_n),
        .entry        (entry),
        .req_addr     (req_addr),
        .reqcyc       (reqcyc),
        .reqack       (reqack),
        .respcyc      (respcyc),
        .resp         (resp),
        .redirect     (dec_ctl.redirect),
        .target       (dec_ctl.target),
        .free_lines   (free_lines),
        .line_written (line_written | credit_return),
        .line_out     (line_resp)
    );

    line_aligner i_aligner (
        .bus           (bus),
        .rst_n         (rst_n),
        .line_in       (line_resp),
        .flush         (dec_ctl.redirect),
        .chunk         (chunk),
        .credit_return (credit_return)
    );

    decode_buffer #(
        .BUF_BYTES (BUF_BYTES)
    ) i_buffer (
        .bus          (bus),
        .rst_n        (rst_n),
        .chunk        (chunk),
        .consume      (dec_ctl.consume),
        .flush        (dec_ctl.redirect),
        .window       (window),
        .window_valid (window_valid),
        .free_lines   (free_lines),
        .line_written (line_written)
    );

endmodule

/* flist.f */
fetch_pkg.sv
fetch_requester.sv
line_aligner.sv
decode_buffer.sv
fetch_unit.sv
tb_clock_gen.sv
tb_mem_model.sv
tb_fetch_unit.sv

/* line_aligner.sv */
`timescale 1ns/10ps

module line_aligner
    import fetch_pkg::*;
(
    input  logic        bus,
    input  logic        rst_n,
    input  line_resp_t  line_in,
    input  logic        flush,
    output chunk_t      chunk,
    output logic        credit_return
);

    logic              keep;
    line_data_t        shifted;
    logic [OFFS_W:0]   kept_bytes;

    logic              chunk_vld;
    line_data_t        chunk_bytes;
    logic [OFFS_W:0]   chunk_cnt;

    // Only fresh lines make it into the buffer
    assign keep = line_in.valid && !line_in.discard && !flush;

    // Shift the bytes after skip up to byte 0
    assign shifted = line_in.data << {line_in.skip, 3'b000};

    assign kept_bytes = (OFFS_W+1)'(LINE_BYTES) - {1'b0, line_in.skip};

    always_ff @(posedge bus) begin
        if (!rst_n) begin
            chunk_vld     <= 1'b0;
            credit_return <= 1'b0;
        end else begin
            chunk_vld     <= keep;
            // Dropped lines still hand their credit back
            credit_return <= line_in.valid && !keep;
        end
    end

    // Payload only, qualified by chunk_vld
    always_ff @(posedge bus) begin
        if (keep) begin
            chunk_bytes <= shifted;
            chunk_cnt   <= kept_bytes;
        end
    end

    assign chunk = '{valid: chunk_vld, bytes: chunk_bytes, count: chunk_cnt};

endmodule

/* run.sh */
#!/usr/bin/env bash
# Build the fetch unit testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module tb_fetch_unit -f flist.f -o tb_fetch_unit_sim \
    && ./obj_dir/tb_fetch_unit_sim | tee /dev/stderr | grep -Fx '>>> PASS' > /dev/null \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

/* tb_clock_gen.sv */
`timescale 1ns/10ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 10
) (
    output logic bus,
    output logic rst_n
);

    initial begin
        bus = 1'b0;
        forever begin
            #(PERIOD_NS / 2) bus = ~bus;
        end
    end

    // Reset leaves on a falling edge, like the other inputs
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge bus);
        @(negedge bus);
        rst_n = 1'b1;
    end

endmodule

/* tb_fetch_unit.sv */
`timescale 1ns/10ps

module tb_fetch_unit
    import fetch_pkg::*;
();

    localparam int          PERIOD_NS      = 100;
    localparam int          RESET_CYCLES   = 10;
    localparam int          BUF_BYTES      = 128;
    localparam logic [31:0] SEED           = 32'h62a5;
    localparam int          NUM_STEPS      = 200;   // Decode steps, each waits for a window
    localparam int          STEP_WORST     = 18;    // Stale drain and refill after a redirect
    localparam int          SETTLE_CYCLES  = 80;
    localparam int          HOLD_CYCLES    = 120;
    localparam int          TIMEOUT_CYCLES = NUM_STEPS * STEP_WORST + HOLD_CYCLES
                                             + RESET_CYCLES + 270;
    localparam line_addr_t  ENTRY_ADDR     = 64'h0000_0000_0001_f0ab;   // Skip of 43

    logic        bus;
    logic        rst_n;
    line_addr_t  entry;
    line_addr_t  req_addr;
    logic        reqcyc;
    logic        reqack;
    logic        respcyc;
    line_data_t  resp;
    decode_ctl_t dec_ctl;
    window_t     window;
    logic        window_valid;

    logic [31:0] lfsr;
    line_addr_t  model_addr;          // Address of window byte 0
    line_addr_t  redirect_target;
    line_addr_t  entry_line;
    line_addr_t  last_req_addr;
    window_t     last_window;
    window_t     exp_window;
    logic [7:0]  exp_target_byte;
    logic        first_req;
    logic        after_redirect;
    logic        hold_check;
    int          redirects      = 0;
    int          reset_errors   = 0;
    int          request_errors = 0;
    int          window_errors  = 0;
    int          hold_errors    = 0;

    tb_clock_gen #(
        .PERIOD_NS    (PERIOD_NS),
        .RESET_CYCLES (RESET_CYCLES)
    ) i_clock_gen (
        .bus   (bus),
        .rst_n (rst_n)
    );

    fetch_unit #(
        .BUF_BYTES (BUF_BYTES)
    ) i_dut (
        .bus          (bus),
        .rst_n        (rst_n),
        .entry        (entry),
        .req_addr     (req_addr),
        .reqcyc       (reqcyc),
        .reqack       (reqack),
        .respcyc      (respcyc),
        .resp         (resp),
        .dec_ctl      (dec_ctl),
        .window       (window),
        .window_valid (window_valid)
    );

    tb_mem_model #(
        .SEED (SEED)
    ) i_mem (
        .bus      (bus),
        .rst_n    (rst_n),
        .req_addr (req_addr),
        .reqcyc   (reqcyc),
        .reqack   (reqack),
        .respcyc  (respcyc),
        .resp     (resp)
    );

    function automatic logic [31:0] draw_bits(input int n);
        logic        fb;
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < n; i++) begin
            fb    = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr  = {lfsr[30:0], fb};
            value = {value[30:0], fb};
        end
        return value;
    endfunction

    function automatic logic [7:0] mem_byte(line_addr_t a);
        return a[7:0] ^ a[15:8];
    endfunction

    function automatic window_t expected_window(line_addr_t addr);
        window_t w;
        for (int k = 0; k < WINDOW_BYTES; k++) begin
            w[(WINDOW_BYTES-1-k)*8 +: 8] = mem_byte(addr + line_addr_t'(k));
        end
        return w;
    endfunction

    assign entry_line      = entry & ~line_addr_t'(LINE_BYTES - 1);
    assign exp_window      = expected_window(model_addr);
    assign exp_target_byte = mem_byte(redirect_target);

    // Reference read address and bookkeeping flags
    always @(posedge bus) begin
        last_req_addr <= req_addr;
        last_window   <= window;
        if (!rst_n) begin
            model_addr     <= entry;
            first_req      <= 1'b1;
            after_redirect <= 1'b0;
        end else begin
            if (reqcyc) begin
                first_req <= 1'b0;
            end
            if (dec_ctl.redirect) begin
                model_addr      <= dec_ctl.target;
                redirect_target <= dec_ctl.target;
                after_redirect  <= 1'b1;
            end else if (window_valid) begin
                model_addr     <= model_addr + line_addr_t'(dec_ctl.consume);
                after_redirect <= 1'b0;    // First window after the redirect seen
            end
        end
    end

    reset_quiet: assert property (@(posedge bus) !rst_n |=> !reqcyc && !window_valid)
        else begin
            reset_errors++;
            $display("error reqcyc %h window_valid %h, both expected 0 after reset",
                     reqcyc, window_valid);
        end

    first_req_at_entry: assert property (@(posedge bus) disable iff (!rst_n)
        first_req && reqcyc |-> req_addr == entry_line)
        else begin
            request_errors++;
            $display("error req_addr: got %h expected %h", req_addr, entry_line);
        end

    req_held_until_ack: assert property (@(posedge bus) disable iff (!rst_n)
        reqcyc && !reqack && !dec_ctl.redirect |=> reqcyc)
        else begin
            request_errors++;
            $display("reqcyc dropped before reqack was seen");
        end

    req_addr_stable: assert property (@(posedge bus) disable iff (!rst_n)
        reqcyc && !reqack && !dec_ctl.redirect |=> req_addr == last_req_addr)
        else begin
            request_errors++;
            $display("error req_addr: got %h expected %h while waiting for reqack",
                     req_addr, last_req_addr);
        end

    window_matches_memory: assert property (@(posedge bus) disable iff (!rst_n)
        window_valid |-> window == exp_window)
        else begin
            window_errors++;
            $display("error window: got %h expected %h at address %h",
                     window, exp_window, model_addr);
        end

    redirect_empties_buffer: assert property (@(posedge bus) disable iff (!rst_n)
        dec_ctl.redirect |=> !window_valid)
        else begin
            window_errors++;
            $display("error window_valid: got %h expected 0 after redirect", window_valid);
        end

    redirect_starts_at_target: assert property (@(posedge bus) disable iff (!rst_n)
        after_redirect && window_valid |-> window[WINDOW_BYTES*8-1 -: 8] == exp_target_byte)
        else begin
            window_errors++;
            $display("error window byte 0: got %h expected %h for target %h",
                     window[WINDOW_BYTES*8-1 -: 8], exp_target_byte, redirect_target);
        end

    // Decoder stalled, so the buffer fills and the bus goes quiet
    stall_stops_requests: assert property (@(posedge bus) disable iff (!rst_n)
        hold_check |-> !reqcyc)
        else begin
            hold_errors++;
            $display("error reqcyc: got %h expected 0 with consume held at 0", reqcyc);
        end

    stall_keeps_window: assert property (@(posedge bus) disable iff (!rst_n)
        hold_check |-> window_valid)
        else begin
            hold_errors++;
            $display("error window_valid: got %h expected 1 with consume held at 0",
                     window_valid);
        end

    stall_window_stable: assert property (@(posedge bus) disable iff (!rst_n)
        hold_check |=> window == last_window)
        else begin
            hold_errors++;
            $display("error window: got %h expected %h with consume held at 0",
                     window, last_window);
        end

    // Decoder stand-in
    initial begin
        logic [31:0] rnd;
        int          total;
        lfsr       = SEED;
        entry      = ENTRY_ADDR;
        dec_ctl    = '0;
        hold_check = 1'b0;
        @(posedge rst_n);
        @(negedge bus);
        for (int step = 0; step < NUM_STEPS; step++) begin
            dec_ctl = '0;
            while (!window_valid) begin
                @(negedge bus);
            end
            rnd = draw_bits(5);
            if (rnd[4:0] == 5'd0) begin                // About one step in 32
                rnd = draw_bits(24);
                dec_ctl.redirect = 1'b1;
                dec_ctl.target   = line_addr_t'(rnd[23:0]);
                redirects++;
            end else begin
                rnd = draw_bits(4);
                dec_ctl.consume = rnd[3:0];
            end
            @(negedge bus);
        end

        dec_ctl = '0;
        repeat (SETTLE_CYCLES) @(negedge bus);
        hold_check = 1'b1;
        repeat (HOLD_CYCLES - SETTLE_CYCLES) @(negedge bus);
        hold_check = 1'b0;
        repeat (2) @(negedge bus);

        total = reset_errors + request_errors + window_errors + hold_errors;
        $display("steps %0d redirects %0d errors: reset %0d request %0d %s",
                 NUM_STEPS, redirects, reset_errors, request_errors,
                 $sformatf("window %0d hold %0d total %0d",
                           window_errors, hold_errors, total));
        if (total == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge bus);
        $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display(">>> FAIL");
        $finish;
    end

endmodule

/* tb_mem_model.sv */
`timescale 1ns/10ps

module tb_mem_model
    import fetch_pkg::*;
#(
    parameter logic [31:0] SEED = 32'h62a5
) (
    input  logic        bus,
    input  logic        rst_n,
    input  line_addr_t  req_addr,
    input  logic        reqcyc,
    output logic        reqack,
    output logic        respcyc,
    output line_data_t  resp
);

    logic [31:0] lfsr;
    line_addr_t  resp_q[$];       // Acked lines, oldest first

    // Fibonacci LFSR, one step per bit taken
    function automatic logic [31:0] draw_bits(input int n);
        logic        fb;
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < n; i++) begin
            fb    = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr  = {lfsr[30:0], fb};
            value = {value[30:0], fb};
        end
        return value;
    endfunction

    // Byte at address a is a[7:0] ^ a[15:8], byte 0 of the line at the top
    function automatic line_data_t line_data(line_addr_t base);
        line_data_t d;
        line_addr_t a;
        for (int k = 0; k < LINE_BYTES; k++) begin
            a = base + line_addr_t'(k);
            d[(LINE_BYTES-1-k)*8 +: 8] = a[7:0] ^ a[15:8];
        end
        return d;
    endfunction

    initial begin
        logic [31:0] rnd;
        logic        ack_armed;
        logic        resp_armed;
        int          ack_wait;
        int          resp_wait;
        line_addr_t  addr;
        lfsr       = SEED;
        reqack     = 1'b0;
        respcyc    = 1'b0;
        resp       = '0;
        ack_armed  = 1'b0;
        resp_armed = 1'b0;
        ack_wait   = 0;
        resp_wait  = 0;
        forever begin
            @(negedge bus);
            reqack  = 1'b0;
            respcyc = 1'b0;
            if (!rst_n) begin
                resp_q.delete();
                ack_armed  = 1'b0;
                resp_armed = 1'b0;
            end else begin
                if (resp_armed) begin
                    if (resp_wait <= 1) begin
                        addr       = resp_q.pop_front();
                        resp       = line_data(addr);
                        respcyc    = 1'b1;
                        resp_armed = 1'b0;
                    end else begin
                        resp_wait--;
                    end
                end
                if (!reqcyc) begin
                    ack_armed = 1'b0;              // Dropped by a redirect
                end else begin
                    if (!ack_armed) begin
                        rnd       = draw_bits(2);  // 0 to 3 cycles
                        ack_wait  = int'(rnd);
                        ack_armed = 1'b1;
                    end
                    if (ack_wait == 0) begin
                        reqack    = 1'b1;
                        ack_armed = 1'b0;
                        resp_q.push_back(req_addr);
                    end else begin
                        ack_wait--;
                    end
                end
                if (!resp_armed && resp_q.size() > 0) begin
                    rnd        = draw_bits(3);
                    resp_wait  = int'(rnd) + 1;    // 1 to 8 cycles
                    resp_armed = 1'b1;
                end
            end
        end
    end

endmodule
